// File: hdl/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int XLEN = 32;
    localparam int ECODE_W = 5;

    //////////////////////////////////////////////////
    // Enumerated types
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } privilege_t;

    // Same encoding as funct3[1:0] of the CSR instructions
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

    typedef enum logic [4:0] {
        ID_NONE,
        ID_MISA, ID_MVENDORID, ID_MARCHID, ID_MIMPID, ID_MHARTID,
        ID_MSTATUS, ID_MIE, ID_MTVEC,
        ID_MSCRATCH, ID_MEPC, ID_MCAUSE, ID_MTVAL, ID_MIP,
        ID_MCYCLE, ID_MCYCLEH, ID_MINSTRET, ID_MINSTRETH,
        ID_CYCLE, ID_CYCLEH, ID_TIME, ID_TIMEH, ID_INSTRET, ID_INSTRETH
    } csr_id_t;

    //////////////////////////////////////////////////
    // Register addresses
    //////////////////////////////////////////////////

    localparam logic [11:0] ADDR_MSTATUS   = 12'h300;
    localparam logic [11:0] ADDR_MISA      = 12'h301;
    localparam logic [11:0] ADDR_MIE       = 12'h304;
    localparam logic [11:0] ADDR_MTVEC     = 12'h305;
    localparam logic [11:0] ADDR_MSCRATCH  = 12'h340;
    localparam logic [11:0] ADDR_MEPC      = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE    = 12'h342;
    localparam logic [11:0] ADDR_MTVAL     = 12'h343;
    localparam logic [11:0] ADDR_MIP       = 12'h344;
    localparam logic [11:0] ADDR_MCYCLE    = 12'hB00;
    localparam logic [11:0] ADDR_MINSTRET  = 12'hB02;
    localparam logic [11:0] ADDR_MCYCLEH   = 12'hB80;
    localparam logic [11:0] ADDR_MINSTRETH = 12'hB82;
    localparam logic [11:0] ADDR_CYCLE     = 12'hC00;
    localparam logic [11:0] ADDR_TIME      = 12'hC01;
    localparam logic [11:0] ADDR_INSTRET   = 12'hC02;
    localparam logic [11:0] ADDR_CYCLEH    = 12'hC80;
    localparam logic [11:0] ADDR_TIMEH     = 12'hC81;
    localparam logic [11:0] ADDR_INSTRETH  = 12'hC82;
    localparam logic [11:0] ADDR_MVENDORID = 12'hF11;
    localparam logic [11:0] ADDR_MARCHID   = 12'hF12;
    localparam logic [11:0] ADDR_MIMPID    = 12'hF13;
    localparam logic [11:0] ADDR_MHARTID   = 12'hF14;

    // mstatus fields: mie, mpie and mpp
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int MSTATUS_MPP  = 11;

    localparam logic [XLEN-1:0] MSTATUS_MASK = 32'h0000_1888;
    // Software, timer and external bits
    localparam logic [XLEN-1:0] MIE_MASK     = 32'h0000_0888;
    localparam logic [XLEN-1:0] MIP_MASK     = 32'h0000_0888;
    localparam logic [XLEN-1:0] MIMPID_VALUE = 32'h0000_0001;

    function automatic csr_id_t csr_lookup(input logic [11:0] addr);
        case (addr)
            ADDR_MISA      : return ID_MISA;
            ADDR_MVENDORID : return ID_MVENDORID;
            ADDR_MARCHID   : return ID_MARCHID;
            ADDR_MIMPID    : return ID_MIMPID;
            ADDR_MHARTID   : return ID_MHARTID;
            ADDR_MSTATUS   : return ID_MSTATUS;
            ADDR_MIE       : return ID_MIE;
            ADDR_MTVEC     : return ID_MTVEC;
            ADDR_MSCRATCH  : return ID_MSCRATCH;
            ADDR_MEPC      : return ID_MEPC;
            ADDR_MCAUSE    : return ID_MCAUSE;
            ADDR_MTVAL     : return ID_MTVAL;
            ADDR_MIP       : return ID_MIP;
            ADDR_MCYCLE    : return ID_MCYCLE;
            ADDR_MCYCLEH   : return ID_MCYCLEH;
            ADDR_MINSTRET  : return ID_MINSTRET;
            ADDR_MINSTRETH : return ID_MINSTRETH;
            ADDR_CYCLE     : return ID_CYCLE;
            ADDR_CYCLEH    : return ID_CYCLEH;
            ADDR_TIME      : return ID_TIME;
            ADDR_TIMEH     : return ID_TIMEH;
            ADDR_INSTRET   : return ID_INSTRET;
            ADDR_INSTRETH  : return ID_INSTRETH;
            default        : return ID_NONE;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hdl/csr_control.sv
`default_nettype none

module csr_control
    import csr_pkg::*;
(
    input  logic             clk,
    input  logic             rst,

    // Request from the core
    input  logic [11:0]      csr_addr,
    input  csr_op_t          csr_op,
    input  logic [XLEN-1:0]  rs1,
    input  logic             new_request,
    input  logic             commit,

    // Trap control
    input  logic             exception_valid,
    input  logic             mret,
    input  privilege_t       mpp,

    // Registered read value, operand of the set/clear ops
    input  logic [XLEN-1:0]  read_value,

    output csr_id_t          csr_id,
    output logic             csr_exception,
    output logic             write_en,
    output logic [XLEN-1:0]  write_data,
    output privilege_t       privilege
);

    logic invalid_addr;
    logic privilege_fault;
    logic read_only;

    //////////////////////////////////////////////////
    // Address decode and access check
    //////////////////////////////////////////////////

    // Single lookup, shared by the datapath through csr_id
    assign csr_id = csr_lookup(csr_addr);

    assign invalid_addr = (csr_id == ID_NONE);

    // Bits 9:8 hold the lowest privilege allowed to access the register
    assign privilege_fault = (csr_addr[9:8] > privilege);

    assign csr_exception = new_request & (invalid_addr | privilege_fault);

    //////////////////////////////////////////////////
    // Read-modify-write
    //////////////////////////////////////////////////

    always_comb begin
        case (csr_op)
            CSR_RW  : write_data = rs1;
            CSR_RS  : write_data = read_value | rs1;
            CSR_RC  : write_data = read_value & ~rs1;
            default : write_data = rs1;
        endcase
    end

    // 2'b11 in the top bits marks a read-only register
    assign read_only = (csr_addr[11:10] == 2'b11);
    assign write_en = commit & ~read_only;

    //////////////////////////////////////////////////
    // Current privilege
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            privilege <= PRIV_MACHINE;
        end else if (exception_valid) begin
            // All traps go to machine mode
            privilege <= PRIV_MACHINE;
        end else if (mret) begin
            privilege <= mpp;
        end
    end

endmodule

`default_nettype wire

// File: hdl/csr_trap_regs.sv
`default_nettype none

module csr_trap_regs
    import csr_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    // Software write port
    input  csr_id_t             csr_id,
    input  logic                write_en,
    input  logic [XLEN-1:0]     write_data,
    input  privilege_t          privilege,

    // Trap entry and return
    input  logic                exception_valid,
    input  logic [ECODE_W-1:0]  exception_code,
    input  logic [XLEN-1:0]     exception_tval,
    input  logic [XLEN-1:0]     exception_pc,
    input  logic                mret,

    output logic [XLEN-1:0]     mstatus,
    output logic [XLEN-1:0]     mtvec,
    output logic [XLEN-1:0]     mepc,
    output logic [XLEN-1:0]     mcause,
    output logic [XLEN-1:0]     mtval,
    output logic [XLEN-1:0]     mie,
    output logic [XLEN-1:0]     mip,
    output logic [XLEN-1:0]     mscratch,
    output privilege_t          mpp
);

    logic wr_mstatus;
    logic wr_mtvec;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mtval;
    logic wr_mie;
    logic wr_mip;
    logic wr_mscratch;

    logic [XLEN-1:0] mstatus_write;
    logic [XLEN-1:0] mstatus_entry;
    logic [XLEN-1:0] mstatus_return;

    // Word-aligned bases, low two bits tied to zero
    logic [XLEN-1:2] mtvec_base;
    logic [XLEN-1:2] mepc_base;

    assign wr_mstatus  = write_en && (csr_id == ID_MSTATUS);
    assign wr_mtvec    = write_en && (csr_id == ID_MTVEC);
    assign wr_mepc     = write_en && (csr_id == ID_MEPC);
    assign wr_mcause   = write_en && (csr_id == ID_MCAUSE);
    assign wr_mtval    = write_en && (csr_id == ID_MTVAL);
    assign wr_mie      = write_en && (csr_id == ID_MIE);
    assign wr_mip      = write_en && (csr_id == ID_MIP);
    assign wr_mscratch = write_en && (csr_id == ID_MSCRATCH);

    //////////////////////////////////////////////////
    // mstatus
    //////////////////////////////////////////////////

    always_comb begin
        mstatus_write = write_data & MSTATUS_MASK;
        // No supervisor mode, so mpp only holds user or machine
        if (write_data[MSTATUS_MPP +: 2] != PRIV_MACHINE)
            mstatus_write[MSTATUS_MPP +: 2] = PRIV_USER;

        mstatus_entry = mstatus;
        mstatus_entry[MSTATUS_MPIE] = mstatus[MSTATUS_MIE];
        mstatus_entry[MSTATUS_MIE] = 1'b0;
        mstatus_entry[MSTATUS_MPP +: 2] = privilege;

        mstatus_return = mstatus;
        mstatus_return[MSTATUS_MIE] = mstatus[MSTATUS_MPIE];
        mstatus_return[MSTATUS_MPIE] = 1'b1;
        mstatus_return[MSTATUS_MPP +: 2] = PRIV_USER;
    end

    always_ff @(posedge clk) begin
        if (rst)
            mstatus <= {{(XLEN-MSTATUS_MPP-2){1'b0}}, PRIV_MACHINE, {MSTATUS_MPP{1'b0}}};
        else if (exception_valid)
            mstatus <= mstatus_entry;
        else if (mret)
            mstatus <= mstatus_return;
        else if (wr_mstatus)
            mstatus <= mstatus_write;
    end

    assign mpp = privilege_t'(mstatus[MSTATUS_MPP +: 2]);

    //////////////////////////////////////////////////
    // Trap vector and trap state
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_mtvec)
            mtvec_base <= write_data[XLEN-1:2];
        if (exception_valid)
            mepc_base <= exception_pc[XLEN-1:2];
        else if (wr_mepc)
            mepc_base <= write_data[XLEN-1:2];
        if (exception_valid)
            mtval <= exception_tval;
        else if (wr_mtval)
            mtval <= write_data;
        if (wr_mscratch)
            mscratch <= write_data;
    end

    assign mtvec = {mtvec_base, 2'b00};
    assign mepc = {mepc_base, 2'b00};

    // Interrupt flag in bit 31, code in the low bits
    always_ff @(posedge clk) begin
        if (rst)
            mcause <= '0;
        else if (exception_valid)
            mcause <= {1'b0, {(XLEN-ECODE_W-1){1'b0}}, exception_code};
        else if (wr_mcause)
            mcause <= {write_data[XLEN-1], {(XLEN-ECODE_W-1){1'b0}},
                       write_data[ECODE_W-1:0]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mie <= '0;
            mip <= '0;
        end else begin
            if (wr_mie)
                mie <= write_data & MIE_MASK;
            if (wr_mip)
                mip <= write_data & MIP_MASK;
        end
    end

endmodule

`default_nettype wire

// File: hdl/csr_counters.sv
`default_nettype none

module csr_counters #(
    parameter int COUNTER_W = 64,
    parameter int RETIRE_W  = 2
) (
    input  logic                  clk,
    input  logic                  rst,

    // Instructions retired this cycle
    input  logic [RETIRE_W-1:0]   retire_inc,

    output logic [COUNTER_W-1:0]  mcycle,
    output logic [COUNTER_W-1:0]  minstret
);

    //////////////////////////////////////////////////
    // Free-running counters
    //////////////////////////////////////////////////

    // Cycle count, also used for the time alias
    always_ff @(posedge clk) begin
        if (rst)
            mcycle <= '0;
        else
            mcycle <= mcycle + 1'b1;
    end

    // Retired instructions, up to 2**RETIRE_W-1 per cycle
    always_ff @(posedge clk) begin
        if (rst)
            minstret <= '0;
        else
            minstret <= minstret + COUNTER_W'(retire_inc);
    end

endmodule

`default_nettype wire

// File: hdl/csr_read_mux.sv
`default_nettype none

module csr_read_mux
    import csr_pkg::*;
#(
    parameter int          COUNTER_W = 64,
    parameter int unsigned HART_ID   = 0
) (
    input  logic                  clk,
    input  csr_id_t               csr_id,
    input  logic                  read_regs,

    // Trap registers
    input  logic [XLEN-1:0]       mstatus,
    input  logic [XLEN-1:0]       mtvec,
    input  logic [XLEN-1:0]       mepc,
    input  logic [XLEN-1:0]       mcause,
    input  logic [XLEN-1:0]       mtval,
    input  logic [XLEN-1:0]       mie,
    input  logic [XLEN-1:0]       mip,
    input  logic [XLEN-1:0]       mscratch,

    // Counters
    input  logic [COUNTER_W-1:0]  mcycle,
    input  logic [COUNTER_W-1:0]  minstret,

    output logic [XLEN-1:0]       read_value
);

    // MXL = 1 for 32 bits, extension I only
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_0100;

    logic [XLEN-1:0] cycle_hi;
    logic [XLEN-1:0] instret_hi;
    logic [XLEN-1:0] selected;

    // Upper counter bits, zero-extended
    assign cycle_hi = XLEN'(mcycle[COUNTER_W-1:XLEN]);
    assign instret_hi = XLEN'(minstret[COUNTER_W-1:XLEN]);

    always_comb begin
        case (csr_id)
            ID_MISA      : selected = MISA_VALUE;
            ID_MVENDORID : selected = '0;
            ID_MARCHID   : selected = '0;
            ID_MIMPID    : selected = MIMPID_VALUE;
            ID_MHARTID   : selected = XLEN'(HART_ID);
            ID_MSTATUS   : selected = mstatus;
            ID_MIE       : selected = mie;
            ID_MTVEC     : selected = mtvec;
            ID_MSCRATCH  : selected = mscratch;
            ID_MEPC      : selected = mepc;
            ID_MCAUSE    : selected = mcause;
            ID_MTVAL     : selected = mtval;
            ID_MIP       : selected = mip;
            // Machine names and user aliases share the counters
            ID_MCYCLE, ID_CYCLE, ID_TIME       : selected = mcycle[XLEN-1:0];
            ID_MCYCLEH, ID_CYCLEH, ID_TIMEH    : selected = cycle_hi;
            ID_MINSTRET, ID_INSTRET            : selected = minstret[XLEN-1:0];
            ID_MINSTRETH, ID_INSTRETH          : selected = instret_hi;
            default      : selected = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (read_regs)
            read_value <= selected;
    end

endmodule

`default_nettype wire

// File: hdl/csr_unit.sv
`default_nettype none

module csr_unit
    import csr_pkg::*;
#(
    parameter int          COUNTER_W = 64,
    parameter int          RETIRE_W  = 2,
    parameter int unsigned HART_ID   = 0
) (
    input  logic                clk,
    input  logic                rst,

    // Request
    input  logic [11:0]         csr_addr,
    input  csr_op_t             csr_op,
    input  logic [XLEN-1:0]     rs1,
    input  logic                new_request,
    input  logic                read_regs,
    input  logic                commit,

    // Trap entry and return
    input  logic                exception_valid,
    input  logic [ECODE_W-1:0]  exception_code,
    input  logic [XLEN-1:0]     exception_tval,
    input  logic [XLEN-1:0]     exception_pc,
    input  logic                mret,

    input  logic [RETIRE_W-1:0] retire_inc,

    output logic                csr_exception,
    output privilege_t          current_privilege,
    output logic [XLEN-1:0]     wb_csr,
    output logic [XLEN-1:0]     trap_pc,
    output logic [XLEN-1:0]     csr_mepc
);

    csr_id_t    csr_id;
    logic       write_en;
    privilege_t mpp;

    logic [XLEN-1:0] write_data;
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] mscratch;

    logic [COUNTER_W-1:0] mcycle;
    logic [COUNTER_W-1:0] minstret;

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////

    csr_control u_control (
        .clk             (clk),
        .rst             (rst),
        .csr_addr        (csr_addr),
        .csr_op          (csr_op),
        .rs1             (rs1),
        .new_request     (new_request),
        .commit          (commit),
        .exception_valid (exception_valid),
        .mret            (mret),
        .mpp             (mpp),
        .read_value      (wb_csr),
        .csr_id          (csr_id),
        .csr_exception   (csr_exception),
        .write_en        (write_en),
        .write_data      (write_data),
        .privilege       (current_privilege)
    );

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////

    csr_trap_regs u_trap_regs (
        .clk             (clk),
        .rst             (rst),
        .csr_id          (csr_id),
        .write_en        (write_en),
        .write_data      (write_data),
        .privilege       (current_privilege),
        .exception_valid (exception_valid),
        .exception_code  (exception_code),
        .exception_tval  (exception_tval),
        .exception_pc    (exception_pc),
        .mret            (mret),
        .mstatus         (mstatus),
        .mtvec           (trap_pc),
        .mepc            (csr_mepc),
        .mcause          (mcause),
        .mtval           (mtval),
        .mie             (mie),
        .mip             (mip),
        .mscratch        (mscratch),
        .mpp             (mpp)
    );

    csr_counters #(
        .COUNTER_W (COUNTER_W),
        .RETIRE_W  (RETIRE_W)
    ) u_counters (
        .clk        (clk),
        .rst        (rst),
        .retire_inc (retire_inc),
        .mcycle     (mcycle),
        .minstret   (minstret)
    );

    // Registered read value doubles as the write-back data
    csr_read_mux #(
        .COUNTER_W (COUNTER_W),
        .HART_ID   (HART_ID)
    ) u_read_mux (
        .clk        (clk),
        .csr_id     (csr_id),
        .read_regs  (read_regs),
        .mstatus    (mstatus),
        .mtvec      (trap_pc),
        .mepc       (csr_mepc),
        .mcause     (mcause),
        .mtval      (mtval),
        .mie        (mie),
        .mip        (mip),
        .mscratch   (mscratch),
        .mcycle     (mcycle),
        .minstret   (minstret),
        .read_value (wb_csr)
    );

endmodule

`default_nettype wire

// File: verification/csr_unit_chk.sv
`default_nettype none

module csr_unit_chk
    import csr_pkg::*;
(
    input wire logic            clk,
    input wire logic            rst,
    input wire logic            new_request,
    input wire logic            csr_exception,
    input wire logic            exception_valid,
    input wire privilege_t      current_privilege,
    input wire logic [XLEN-1:0] trap_pc
);

    timeunit 1ns;
    timeprecision 1ps;

    // Read by the testbench at the end of the run
    int fail_count = 0;

    //////////////////////////////////////////////////
    // Protocol properties
    //////////////////////////////////////////////////

    // Exception only alongside a request
    a_exception_needs_request: assert property (
        @(posedge clk) disable iff (rst) csr_exception |-> new_request
    ) else begin
        fail_count++;
        $error("csr_exception high without new_request");
    end

    a_reset_state: assert property (
        @(posedge clk) $fell(rst) |-> (current_privilege == PRIV_MACHINE) && !csr_exception
    ) else begin
        fail_count++;
        $error("unit not in machine mode or exception raised after reset");
    end

    // Trap vector is word aligned
    a_trap_pc_aligned: assert property (
        @(posedge clk) disable iff (rst) trap_pc[1:0] == 2'b00
    ) else begin
        fail_count++;
        $error("trap_pc low bits not zero");
    end

    a_trap_to_machine: assert property (
        @(posedge clk) disable iff (rst) exception_valid |=> current_privilege == PRIV_MACHINE
    ) else begin
        fail_count++;
        $error("privilege not machine after exception");
    end

endmodule

bind csr_unit csr_unit_chk u_chk (
    .clk               (clk),
    .rst               (rst),
    .new_request       (new_request),
    .csr_exception     (csr_exception),
    .exception_valid   (exception_valid),
    .current_privilege (current_privilege),
    .trap_pc           (trap_pc)
);

`default_nettype wire

// File: verification/csr_unit_tb.sv
`default_nettype none

module csr_unit_tb
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          COUNTER_W = 64;
    localparam int          RETIRE_W  = 2;
    localparam int unsigned HART_ID   = 0;
    localparam int          TIMEOUT   = 50;
    // Idle cycles between the two mcycle reads
    localparam int          GAP       = 5;
    localparam int          WINDOW    = 12;
    localparam logic [31:0] MISA_EXP  = 32'h4000_0000 | (32'h1 << 8);

    logic                clk;
    logic                rst;
    logic [11:0]         csr_addr;
    csr_op_t             csr_op;
    logic [XLEN-1:0]     rs1;
    logic                new_request;
    logic                read_regs;
    logic                commit;
    logic                exception_valid;
    logic [ECODE_W-1:0]  exception_code;
    logic [XLEN-1:0]     exception_tval;
    logic [XLEN-1:0]     exception_pc;
    logic                mret;
    logic [RETIRE_W-1:0] retire_inc;
    logic                csr_exception;
    privilege_t          current_privilege;
    logic [XLEN-1:0]     wb_csr;
    logic [XLEN-1:0]     trap_pc;
    logic [XLEN-1:0]     csr_mepc;
    logic [15:0]         lfsr_state;

    csr_unit #(
        .COUNTER_W (COUNTER_W),
        .RETIRE_W  (RETIRE_W),
        .HART_ID   (HART_ID)
    ) u_dut (
        .clk               (clk),
        .rst               (rst),
        .csr_addr          (csr_addr),
        .csr_op            (csr_op),
        .rs1               (rs1),
        .new_request       (new_request),
        .read_regs         (read_regs),
        .commit            (commit),
        .exception_valid   (exception_valid),
        .exception_code    (exception_code),
        .exception_tval    (exception_tval),
        .exception_pc      (exception_pc),
        .mret              (mret),
        .retire_inc        (retire_inc),
        .csr_exception     (csr_exception),
        .current_privilege (current_privilege),
        .wb_csr            (wb_csr),
        .trap_pc           (trap_pc),
        .csr_mepc          (csr_mepc)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected)
        else fail_run($sformatf("Mismatch at %0d ns: %s read %h, expected %h",
                                $time, what, got, expected));
    endtask

    // Any failure of the bound checker ends the run
    always @(posedge clk) begin
        if (u_dut.u_chk.fail_count != 0)
            fail_run("Protocol assertion failed in the bound checker");
    end

    task automatic wait_privilege(input privilege_t target);
        int cycles;
        cycles = 0;
        while (current_privilege !== target) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                fail_run($sformatf("Timeout: privilege never became %s", target.name()));
        end
    endtask

    // One read strobe, capture lands in wb_csr a cycle later
    task automatic read_csr(input logic [11:0] addr, input logic exp_exc,
                            output logic [31:0] value);
        @(posedge clk);
        csr_addr <= addr;
        new_request <= 1'b1;
        read_regs <= 1'b1;
        @(negedge clk);
        check_value($sformatf("csr_exception at %h", addr), 32'(csr_exception), 32'(exp_exc));
        @(posedge clk);
        new_request <= 1'b0;
        read_regs <= 1'b0;
        @(negedge clk);
        value = wb_csr;
    endtask

    task automatic csr_access(input logic [11:0] addr, input csr_op_t op,
                              input logic [31:0] data, output logic [31:0] old_val,
                              output logic [31:0] new_val);
        @(posedge clk);
        csr_op <= op;
        rs1 <= data;
        read_csr(addr, 1'b0, old_val);
        @(posedge clk);
        commit <= 1'b1;
        @(posedge clk);
        commit <= 1'b0;
        read_csr(addr, 1'b0, new_val);
    endtask

    task automatic raise_exception(input logic [31:0] code, input logic [31:0] tval,
                                   input logic [31:0] pc);
        @(posedge clk);
        exception_valid <= 1'b1;
        exception_code <= code[ECODE_W-1:0];
        exception_tval <= tval;
        exception_pc <= pc;
        @(posedge clk);
        exception_valid <= 1'b0;
        wait_privilege(PRIV_MACHINE);
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin : main
        logic [31:0] d0, d1, d2, old_val, new_val, value, first, second;
        logic [31:0] code, tval, pc;
        int retire_sum;
        clk = 1'b0;
        rst = 1'b1;
        csr_addr = '0;
        csr_op = CSR_RW;
        rs1 = '0;
        new_request = 1'b0;
        read_regs = 1'b0;
        commit = 1'b0;
        exception_valid = 1'b0;
        exception_code = '0;
        exception_tval = '0;
        exception_pc = '0;
        mret = 1'b0;
        retire_inc = '0;
        lfsr_state = 16'd61295;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        wait_privilege(PRIV_MACHINE);
        read_csr(ADDR_MSTATUS, 1'b0, value);
        check_value("mstatus after reset", value, 32'h0000_1800);
        read_csr(ADDR_MCAUSE, 1'b0, value);
        check_value("mcause after reset", value, 32'h0);

        // Read-modify-write on mscratch
        random_bits(32, d0);
        random_bits(32, d1);
        random_bits(32, d2);
        csr_access(ADDR_MSCRATCH, CSR_RW, d0, old_val, new_val);
        check_value("mscratch RW", new_val, d0);
        csr_access(ADDR_MSCRATCH, CSR_RS, d1, old_val, new_val);
        check_value("mscratch RS old", old_val, d0);
        check_value("mscratch RS", new_val, d0 | d1);
        csr_access(ADDR_MSCRATCH, CSR_RC, d2, old_val, new_val);
        check_value("mscratch RC", new_val, (d0 | d1) & ~d2);

        // Writable-bit masks and constant registers
        csr_access(ADDR_MSTATUS, CSR_RW, '1, old_val, new_val);
        check_value("mstatus mask", new_val, MSTATUS_MASK);
        csr_access(ADDR_MIE, CSR_RW, '1, old_val, new_val);
        check_value("mie mask", new_val, MIE_MASK);
        csr_access(ADDR_MIP, CSR_RW, '1, old_val, new_val);
        check_value("mip mask", new_val, MIP_MASK);
        csr_access(ADDR_MTVEC, CSR_RW, '1, old_val, new_val);
        check_value("mtvec", new_val, 32'hFFFF_FFFC);
        check_value("trap_pc", trap_pc, 32'hFFFF_FFFC);
        csr_access(ADDR_MHARTID, CSR_RW, '1, old_val, new_val);
        check_value("mhartid", new_val, 32'(HART_ID));
        read_csr(ADDR_MISA, 1'b0, value);
        check_value("misa", value, MISA_EXP);

        // Trap entry from machine mode with mie set and mpie clear
        csr_access(ADDR_MSTATUS, CSR_RW, 32'h0000_1808, old_val, new_val);
        random_bits(ECODE_W, code);
        random_bits(32, tval);
        random_bits(32, pc);
        raise_exception(code, tval, pc);
        @(negedge clk);
        check_value("csr_mepc", csr_mepc, pc & ~32'h3);
        read_csr(ADDR_MEPC, 1'b0, value);
        check_value("mepc", value, pc & ~32'h3);
        read_csr(ADDR_MCAUSE, 1'b0, value);
        check_value("mcause", value, code);
        read_csr(ADDR_MTVAL, 1'b0, value);
        check_value("mtval", value, tval);
        read_csr(ADDR_MSTATUS, 1'b0, value);
        check_value("mstatus on entry", value, (32'h1 << 7) | (32'h3 << 11));

        // Clear mpp, keep mpie set, then return to user mode
        csr_access(ADDR_MSTATUS, CSR_RC, 32'h0000_1800, old_val, new_val);
        check_value("mstatus cleared", new_val, 32'h1 << 7);
        @(posedge clk);
        mret <= 1'b1;
        @(posedge clk);
        mret <= 1'b0;
        wait_privilege(PRIV_USER);
        read_csr(ADDR_MSTATUS, 1'b1, value);
        check_value("mstatus on mret", value, (32'h1 << 7) | (32'h1 << 3));
        read_csr(ADDR_MSCRATCH, 1'b1, value);
        read_csr(ADDR_MHARTID, 1'b1, value);
        read_csr(ADDR_MCYCLE, 1'b1, value);
        read_csr(ADDR_CYCLE, 1'b0, value);
        read_csr(ADDR_INSTRET, 1'b0, value);
        random_bits(ECODE_W, code);
        random_bits(32, tval);
        random_bits(32, pc);
        raise_exception(code, tval, pc);
        // mpp now records user, mpie the set mie
        read_csr(ADDR_MSTATUS, 1'b0, value);
        check_value("mstatus from user", value, 32'h1 << 7);

        // Unimplemented address and counters
        read_csr(12'h7C0, 1'b1, value);
        read_csr(ADDR_MCYCLE, 1'b0, first);
        repeat (GAP) @(posedge clk);
        read_csr(ADDR_MCYCLE, 1'b0, second);
        check_value("mcycle spacing", second - first, GAP + 2);
        retire_sum = 0;
        read_csr(ADDR_MINSTRET, 1'b0, first);
        for (int i = 0; i < WINDOW; i++) begin
            random_bits(RETIRE_W, d0);
            @(posedge clk);
            retire_inc <= d0[RETIRE_W-1:0];
            retire_sum += d0[RETIRE_W-1:0];
        end
        @(posedge clk);
        retire_inc <= '0;
        read_csr(ADDR_MINSTRET, 1'b0, second);
        check_value("minstret growth", second - first, retire_sum);

        repeat (2) @(posedge clk);
        if (u_dut.u_chk.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: flist.f
hdl/csr_pkg.sv
hdl/csr_control.sv
hdl/csr_trap_regs.sv
hdl/csr_counters.sv
hdl/csr_read_mux.sv
hdl/csr_unit.sv
verification/csr_unit_chk.sv
verification/csr_unit_tb.sv

// File: Bender.yml
package:
  name: csr_unit

sources:
  - files:
      - hdl/csr_pkg.sv
      - hdl/csr_control.sv
      - hdl/csr_trap_regs.sv
      - hdl/csr_counters.sv
      - hdl/csr_read_mux.sv
      - hdl/csr_unit.sv
  - target: test
    files:
      - verification/csr_unit_chk.sv
      - verification/csr_unit_tb.sv
